// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	localparam int wordWidth = 10; // Data word and address width
	localparam int instrWidth = 16;
	localparam int opcodeWidth = 5;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [instrWidth-1:0] instrT;

	// Top five bits of the instruction, flag and operand follow
	typedef enum logic [opcodeWidth-1:0] {
		opNop = 5'b00000,
		opAdd = 5'b00010,
		opSub = 5'b00011,
		opNot = 5'b00100,
		opPush = 5'b00111, // From memory address
		opPushi = 5'b01000, // Immediate
		opPop = 5'b01010,
		opInc = 5'b01011,
		opDec = 5'b01100,
		opJump = 5'b10000,
		opBlt = 5'b10001,
		opBeq = 5'b10011,
		opBne = 5'b10100,
		opBge = 5'b10101
	} opcodeE;

	typedef enum logic [2:0] {
		aluPass = 3'd0, // Result is b
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluNot = 3'd3,
		aluInc = 3'd4,
		aluDec = 3'd5
	} aluOpE;

endpackage

`default_nettype wire

// ==== src/stackAlu.sv ====
`timescale 1ns/10ps
`default_nettype none

module stackAlu (
	input wire cpuPkg::aluOpE aluOp,
	input wire cpuPkg::wordT a,
	input wire cpuPkg::wordT b,
	output cpuPkg::wordT result,
	output logic zero,
	output logic neg
);
	import cpuPkg::*;

	// All operations wrap modulo 1024
	always_comb begin
		case (aluOp)
			aluPass: begin
				result = b;
			end
			aluAdd: begin
				result = a + b;
			end
			aluSub: begin
				result = a - b; // a is the deeper entry
			end
			aluNot: begin
				result = ~b;
			end
			aluInc: begin
				result = b + wordT'(1);
			end
			aluDec: begin
				result = b - wordT'(1);
			end
			default: begin
				result = b;
			end
		endcase
	end

	assign zero = (result == '0);
	assign neg = result[wordWidth-1]; // Two's complement sign

endmodule

`default_nettype wire

// ==== src/dataRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataRam (
	input wire logic CLK,
	input wire logic we,
	input wire cpuPkg::wordT addr,
	input wire cpuPkg::wordT wdata,
	output cpuPkg::wordT rdata
);
	import cpuPkg::*;

	localparam int depth = 2 ** wordWidth;

	wordT mem [0:depth-1];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge CLK) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== src/memArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module memArbiter (
	input wire logic CLK,
	input wire logic reset,
	input wire logic hostReq,
	input wire logic hostWe,
	input wire cpuPkg::wordT hostAddr,
	input wire cpuPkg::wordT hostWdata,
	output logic hostAck,
	output cpuPkg::wordT hostRdata,
	input wire logic engReq,
	input wire logic engWe,
	input wire cpuPkg::wordT engAddr,
	input wire cpuPkg::wordT engWdata,
	output logic engAck,
	output cpuPkg::wordT engRdata,
	output logic ramWe,
	output cpuPkg::wordT ramAddr,
	output cpuPkg::wordT ramWdata,
	input wire cpuPkg::wordT ramRdata
);

	logic hostGrant;
	logic engGrant;

	// Host first, no peer is granted again in its own ack cycle
	assign hostGrant = hostReq && !hostAck;
	assign engGrant = engReq && !engAck && !hostGrant;

	always_comb begin
		if (hostGrant) begin
			ramWe = hostWe;
			ramAddr = hostAddr;
			ramWdata = hostWdata;
		end else begin
			ramWe = engGrant && engWe; // Idle cycles never write
			ramAddr = engAddr;
			ramWdata = engWdata;
		end
	end

	// Ack registers also record who owns this cycle's read data
	always_ff @(posedge CLK) begin
		if (reset) begin
			hostAck <= 1'b0;
			engAck <= 1'b0;
		end else begin
			hostAck <= hostGrant;
			engAck <= engGrant;
		end
	end

	assign hostRdata = hostAck ? ramRdata : '0;
	assign engRdata = engAck ? ramRdata : '0;

endmodule

`default_nettype wire

// ==== src/stackEngine.sv ====
`timescale 1ns/10ps
`default_nettype none

module stackEngine #(
	parameter cpuPkg::wordT stackBase = 10'd768
) (
	input wire logic CLK,
	input wire logic reset,
	input wire cpuPkg::instrT instr,
	output cpuPkg::wordT instrAddr,
	output logic memReq,
	output logic memWe,
	output cpuPkg::wordT memAddr,
	output cpuPkg::wordT memWdata,
	input wire logic memAck,
	input wire cpuPkg::wordT memRdata,
	output cpuPkg::aluOpE aluOp,
	output cpuPkg::wordT aluA,
	output cpuPkg::wordT aluB,
	input wire cpuPkg::wordT aluResult,
	input wire logic aluZero,
	input wire logic aluNeg
);
	import cpuPkg::*;

	typedef enum logic [2:0] {
		stFetch,
		stDecode,
		stRead,
		stRead2,
		stWrite,
		stBranch
	} stateE;

	stateE state;
	instrT ir;
	opcodeE opcode;
	wordT operand;
	wordT ip;
	wordT sp;
	wordT ax;
	wordT ipNext;
	wordT spPlus1;
	wordT spMinus1;
	wordT spMinus2;
	logic taken;

	assign opcode = opcodeE'(ir[instrWidth-1 -: opcodeWidth]);
	assign operand = ir[wordWidth-1:0]; // Flag bit ignored

	// Address adder, SP points to the next free word
	assign spPlus1 = sp + wordT'(1);
	assign spMinus1 = sp - wordT'(1);
	assign spMinus2 = sp - wordT'(2);
	assign ipNext = ip + wordT'(1);

	assign instrAddr = ip;

	always_ff @(posedge CLK) begin
		if (state == stFetch) begin
			ir <= instr;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stFetch;
			ip <= '0;
			sp <= stackBase;
			ax <= '0;
		end else begin
			case (state)
				stFetch: begin
					state <= stDecode;
				end
				stDecode: begin
					case (opcode)
						opJump: begin
							ip <= operand;
							state <= stFetch;
						end
						opPushi: begin
							state <= stWrite;
						end
						opPush, opPop, opAdd, opSub, opNot, opInc, opDec,
						opBlt, opBeq, opBne, opBge: begin
							state <= stRead;
						end
						default: begin // NOP and unused codes
							ip <= ipNext;
							state <= stFetch;
						end
					endcase
				end
				stRead: begin
					if (memAck) begin
						ax <= memRdata;
						case (opcode)
							opAdd, opSub: state <= stRead2;
							opBlt, opBeq, opBne, opBge: state <= stBranch;
							default: state <= stWrite;
						endcase
					end
				end
				stRead2: begin
					if (memAck) begin
						ax <= aluResult; // Second entry op top
						state <= stWrite;
					end
				end
				stWrite: begin
					if (memAck) begin
						ip <= ipNext;
						state <= stFetch;
						case (opcode)
							opPushi, opPush: sp <= spPlus1;
							opPop, opAdd, opSub: sp <= spMinus1;
							default: sp <= sp; // In place update
						endcase
					end
				end
				stBranch: begin
					ip <= taken ? operand : ipNext;
					sp <= spMinus1;
					state <= stFetch;
				end
				default: begin
					state <= stFetch;
				end
			endcase
		end
	end

	// Flags come from AX passed through the ALU
	always_comb begin
		case (opcode)
			opBeq: taken = aluZero;
			opBne: taken = !aluZero;
			opBlt: taken = aluNeg;
			opBge: taken = !aluNeg;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		aluOp = aluPass;
		aluA = ax;
		aluB = ax;
		if (state == stRead2) begin
			aluA = memRdata;
			if (opcode == opSub) begin
				aluOp = aluSub;
			end else begin
				aluOp = aluAdd;
			end
		end else if (state == stWrite) begin
			case (opcode)
				opNot: aluOp = aluNot;
				opInc: aluOp = aluInc;
				opDec: aluOp = aluDec;
				default: aluOp = aluPass;
			endcase
			if (opcode == opPushi) begin
				aluB = operand;
			end
		end
	end

	assign memReq = (state == stRead) || (state == stRead2) || (state == stWrite);
	assign memWe = (state == stWrite);
	assign memWdata = aluResult; // Write data always goes through the ALU

	always_comb begin
		memAddr = spMinus1;
		case (state)
			stRead: begin
				if (opcode == opPush) begin
					memAddr = operand;
				end
			end
			stRead2: begin
				memAddr = spMinus2;
			end
			stWrite: begin
				case (opcode)
					opPushi, opPush: memAddr = sp;
					opPop: memAddr = operand;
					opAdd, opSub: memAddr = spMinus2;
					default: memAddr = spMinus1;
				endcase
			end
			default: begin
				memAddr = spMinus1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/stackCpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module stackCpu #(
	parameter cpuPkg::wordT stackBase = 10'd768
) (
	input wire logic CLK,
	input wire logic reset,
	input wire cpuPkg::instrT instr,
	output cpuPkg::wordT instrAddr,
	input wire logic hostReq,
	input wire logic hostWe,
	input wire cpuPkg::wordT hostAddr,
	input wire cpuPkg::wordT hostWdata,
	output logic hostAck,
	output cpuPkg::wordT hostRdata
);
	import cpuPkg::*;

	logic engReq;
	logic engWe;
	wordT engAddr;
	wordT engWdata;
	logic engAck;
	wordT engRdata;
	aluOpE aluOp;
	wordT aluA;
	wordT aluB;
	wordT aluResult;
	logic aluZero;
	logic aluNeg;
	logic ramWe;
	wordT ramAddr;
	wordT ramWdata;
	wordT ramRdata;

	stackEngine #(
		.stackBase(stackBase)
	) u_stackEngine (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.instrAddr(instrAddr),
		.memReq(engReq),
		.memWe(engWe),
		.memAddr(engAddr),
		.memWdata(engWdata),
		.memAck(engAck),
		.memRdata(engRdata),
		.aluOp(aluOp),
		.aluA(aluA),
		.aluB(aluB),
		.aluResult(aluResult),
		.aluZero(aluZero),
		.aluNeg(aluNeg)
	);

	stackAlu u_stackAlu (
		.aluOp(aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.zero(aluZero),
		.neg(aluNeg)
	);

	// Host port has priority over the engine
	memArbiter u_memArbiter (
		.CLK(CLK),
		.reset(reset),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostWdata(hostWdata),
		.hostAck(hostAck),
		.hostRdata(hostRdata),
		.engReq(engReq),
		.engWe(engWe),
		.engAddr(engAddr),
		.engWdata(engWdata),
		.engAck(engAck),
		.engRdata(engRdata),
		.ramWe(ramWe),
		.ramAddr(ramAddr),
		.ramWdata(ramWdata),
		.ramRdata(ramRdata)
	);

	dataRam u_dataRam (
		.CLK(CLK),
		.we(ramWe),
		.addr(ramAddr),
		.wdata(ramWdata),
		.rdata(ramRdata)
	);

endmodule

`default_nettype wire

// ==== bench/stackCpuTests.svh ====
`ifndef STACK_CPU_TESTS_SVH
`define STACK_CPU_TESTS_SVH

	// Unused ROM words jump to themselves
	task automatic clearRom();
		wordT a;
		a = '0;
		do begin
			rom[a] = {opJump, 1'b0, a};
			a = a + 10'd1;
		end while (a != '0);
	endtask

	task automatic emit(input opcodeE op, input wordT arg);
		rom[progLen] = {op, 1'b0, arg};
		progLen = progLen + 10'd1;
	endtask

	task automatic emitBinary(input opcodeE op, input wordT a, input wordT b, input wordT dst);
		emit(opPushi, a);
		emit(opPushi, b);
		emit(op, '0);
		emit(opPop, dst);
	endtask

	task automatic emitUnary(input opcodeE op, input wordT a, input wordT dst);
		emit(opPushi, a);
		emit(op, '0);
		emit(opPop, dst);
	endtask

	// Not taken stores dst+100, taken stores dst+200
	task automatic emitBranch(input opcodeE op, input wordT val, input wordT dst);
		wordT base;
		emit(opPushi, val);
		base = progLen;
		emit(op, base + 10'd4);
		emit(opPushi, dst + 10'd100);
		emit(opPop, dst);
		emit(opJump, base + 10'd6);
		emit(opPushi, dst + 10'd200);
		emit(opPop, dst);
	endtask

	function automatic wordT randomWord();
		return wordT'($random(seed));
	endfunction

	task automatic startProgram();
		@(negedge CLK);
		reset = 1'b1; // Engine held while the ROM changes
		clearRom();
		progLen = '0;
	endtask

	task automatic launchProgram();
		endAddr = progLen;
		emit(opJump, endAddr);
		repeat (5) @(negedge CLK);
		reset = 1'b0;
	endtask

	// Executes the ROM program on modelMem
	task automatic runModel();
		opcodeE op;
		wordT ip;
		wordT nextIp;
		wordT sp;
		wordT arg;
		wordT top;
		wordT second;
		logic done;
		int steps;
		ip = '0;
		sp = stackBase;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			op = opcodeE'(rom[ip][15:11]);
			arg = rom[ip][9:0];
			nextIp = ip + 10'd1;
			case (op)
				opPushi: begin
					modelMem[sp] = arg;
					sp = sp + 10'd1;
				end
				opPush: begin
					modelMem[sp] = modelMem[arg];
					sp = sp + 10'd1;
				end
				opPop: begin
					sp = sp - 10'd1;
					modelMem[arg] = modelMem[sp];
				end
				opAdd, opSub: begin
					top = modelMem[sp - 10'd1];
					second = modelMem[sp - 10'd2];
					modelMem[sp - 10'd2] = (op == opAdd) ? second + top : second - top;
					sp = sp - 10'd1;
				end
				opNot: modelMem[sp - 10'd1] = ~modelMem[sp - 10'd1];
				opInc: modelMem[sp - 10'd1] = modelMem[sp - 10'd1] + 10'd1;
				opDec: modelMem[sp - 10'd1] = modelMem[sp - 10'd1] - 10'd1;
				opBeq, opBne, opBlt, opBge: begin
					sp = sp - 10'd1;
					top = modelMem[sp];
					if ((op == opBeq && top == '0) || (op == opBne && top != '0)
						|| (op == opBlt && top[wordWidth-1]) || (op == opBge && !top[wordWidth-1])) begin
						nextIp = arg;
					end
				end
				opJump: begin
					done = (arg == ip);
					nextIp = arg;
				end
				default: begin
					nextIp = ip + 10'd1; // NOP and unused codes
				end
			endcase
			ip = nextIp;
			steps++;
			if (steps > waitLimit) begin
				failRun("reference model ran past its step limit");
			end
		end
	endtask

	task automatic checkMem(input wordT addr);
		wordT got;
		hostRead(addr, got);
		checkValue($sformatf("data word %0d", addr), got, modelMem[addr]);
	endtask

	task automatic expectMarker(input wordT dst, input logic taken);
		wordT got;
		hostRead(dst, got);
		checkValue($sformatf("branch marker %0d", dst), got, modelMem[dst]);
		checkValue($sformatf("branch decision %0d", dst), got,
			taken ? dst + 10'd200 : dst + 10'd100);
	endtask

	task automatic runAndCompare();
		launchProgram();
		waitProgramEnd();
		runModel();
	endtask

	task automatic resetAndHostTest();
		startProgram();
		launchProgram(); // Empty program, IP stays at 0
		checkValue("hostAck after reset", wordT'(hostAck), '0);
		checkValue("instrAddr after reset", instrAddr, '0);
		waitProgramEnd();
		runModel();
		for (int i = 0; i < 6; i++) begin
			hostWrite(10'd37 * wordT'(i) + 10'd20, randomWord());
		end
		for (int i = 0; i < 6; i++) begin
			checkMem(10'd37 * wordT'(i) + 10'd20);
		end
	endtask

	task automatic pushPopTest();
		startProgram();
		for (int i = 0; i < 5; i++) begin
			emit(opPushi, randomWord());
		end
		for (int i = 0; i < 5; i++) begin
			emit(opPop, 10'd200 + wordT'(i)); // Last pushed lands at 200
		end
		runAndCompare();
		for (int i = 0; i < 5; i++) begin
			checkMem(10'd200 + wordT'(i));
		end
	endtask

	task automatic arithmeticTest();
		startProgram();
		emitBinary(opAdd, 10'd1000, 10'd50, 10'd300); // Wraps past 1023
		emitBinary(opSub, 10'd10, 10'd700, 10'd301); // Below 0
		emitUnary(opInc, 10'd1023, 10'd302);
		emitUnary(opDec, 10'd0, 10'd303);
		for (int i = 0; i < 4; i++) begin
			emitBinary(opAdd, randomWord(), randomWord(), 10'd304 + wordT'(i));
			emitBinary(opSub, randomWord(), randomWord(), 10'd308 + wordT'(i));
			emitUnary(opNot, randomWord(), 10'd312 + wordT'(i));
			emitUnary(opInc, randomWord(), 10'd316 + wordT'(i));
			emitUnary(opDec, randomWord(), 10'd320 + wordT'(i));
		end
		runAndCompare();
		for (int i = 0; i < 24; i++) begin
			checkMem(10'd300 + wordT'(i));
		end
	endtask

	task automatic pushFromMemoryTest();
		hostWrite(10'd400, randomWord());
		hostWrite(10'd401, randomWord());
		hostWrite(10'd402, randomWord());
		startProgram();
		emit(opPush, 10'd400);
		emit(opPush, 10'd401);
		emit(opAdd, '0);
		emit(opPush, 10'd402);
		emit(opSub, '0);
		emit(opPop, 10'd410);
		runAndCompare();
		checkMem(10'd410);
		checkMem(10'd400);
		checkMem(10'd401);
		checkMem(10'd402);
	endtask

	task automatic branchTest();
		startProgram();
		emitBranch(opBeq, 10'd0, 10'd500);
		emitBranch(opBeq, 10'd5, 10'd501);
		emitBranch(opBne, 10'd7, 10'd502);
		emitBranch(opBne, 10'd0, 10'd503);
		emitBranch(opBlt, 10'd512, 10'd504); // Most negative value
		emitBranch(opBlt, 10'd511, 10'd505);
		emitBranch(opBge, 10'd0, 10'd506);
		emitBranch(opBge, 10'd1023, 10'd507);
		runAndCompare();
		expectMarker(10'd500, 1'b1);
		expectMarker(10'd501, 1'b0);
		expectMarker(10'd502, 1'b1);
		expectMarker(10'd503, 1'b0);
		expectMarker(10'd504, 1'b1);
		expectMarker(10'd505, 1'b0);
		expectMarker(10'd506, 1'b1);
		expectMarker(10'd507, 1'b0);
	endtask

	task automatic hostTraffic();
		for (int i = 0; i < 16; i++) begin
			hostWrite(10'd150 + wordT'(i), randomWord());
		end
		for (int i = 0; i < 16; i++) begin
			checkMem(10'd150 + wordT'(i));
		end
	endtask

	task automatic contentionTest();
		startProgram();
		for (int i = 0; i < 10; i++) begin
			emitBinary(opAdd, randomWord(), randomWord(), 10'd330 + wordT'(i));
			emitBinary(opSub, randomWord(), randomWord(), 10'd340 + wordT'(i));
			emitUnary(opInc, randomWord(), 10'd350 + wordT'(i));
		end
		launchProgram();
		fork
			waitProgramEnd();
			hostTraffic(); // Host region never touched by the program
		join
		runModel();
		for (int i = 0; i < 30; i++) begin
			checkMem(10'd330 + wordT'(i));
		end
	endtask

`endif

// ==== bench/stackCpuTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module stackCpuTb;
	import cpuPkg::*;

	localparam int waitLimit = 4000; // Cycles allowed for any single wait
	localparam wordT stackBase = 10'd768; // DUT default

	logic CLK;
	logic reset;
	instrT instr;
	wordT instrAddr;
	logic hostReq;
	logic hostWe;
	wordT hostAddr;
	wordT hostWdata;
	logic hostAck;
	wordT hostRdata;

	instrT rom [0:1023];
	wordT modelMem [0:1023]; // Expected data memory
	wordT progLen;
	wordT endAddr;
	integer seed;

	stackCpu u_stackCpu (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.instrAddr(instrAddr),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostWdata(hostWdata),
		.hostAck(hostAck),
		.hostRdata(hostRdata)
	);

	assign instr = rom[instrAddr]; // Combinational ROM

	initial begin
		CLK = 1'b0;
		forever begin
			#2 CLK = ~CLK;
		end
	end

	task automatic failRun(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkValue(input string what, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Run stopped");
		end
	endtask

	task automatic hostWrite(input wordT addr, input wordT data);
		int waitCount;
		@(negedge CLK);
		hostReq = 1'b1;
		hostWe = 1'b1;
		hostAddr = addr;
		hostWdata = data;
		waitCount = 0;
		do begin
			@(negedge CLK);
			waitCount++;
			if (waitCount > waitLimit) begin
				failRun("host write was never acknowledged");
			end
		end while (!hostAck);
		hostReq = 1'b0;
		hostWe = 1'b0;
		modelMem[addr] = data;
	endtask

	task automatic hostRead(input wordT addr, output wordT data);
		int waitCount;
		@(negedge CLK);
		hostReq = 1'b1;
		hostWe = 1'b0;
		hostAddr = addr;
		waitCount = 0;
		do begin
			@(negedge CLK);
			waitCount++;
			if (waitCount > waitLimit) begin
				failRun("host read was never acknowledged");
			end
		end while (!hostAck);
		data = hostRdata; // Valid in the ack cycle only
		hostReq = 1'b0;
	endtask

	// Program is done once IP sits on its final self jump
	task automatic waitProgramEnd();
		int cycles;
		int stable;
		cycles = 0;
		stable = 0;
		while (stable < 8) begin
			@(negedge CLK);
			cycles++;
			if (instrAddr == endAddr) begin
				stable++;
			end else begin
				stable = 0;
			end
			if (cycles > waitLimit) begin
				failRun("program did not reach its final jump in time");
			end
		end
	endtask

	`include "stackCpuTests.svh"

	initial begin
		seed = 93455;
		reset = 1'b1;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWdata = '0;
		progLen = '0;
		endAddr = '0;
		clearRom();
		resetAndHostTest();
		pushPopTest();
		arithmeticTest();
		pushFromMemoryTest();
		branchTest();
		contentionTest();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+bench
src/cpuPkg.sv
src/stackAlu.sv
src/dataRam.sv
src/memArbiter.sv
src/stackEngine.sv
src/stackCpu.sv
bench/stackCpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the stack CPU testbench with Verilator

buildDir=obj_dir
simName=stackCpuSim
logFile=sim.log

verilator --binary --timing --timescale 1ns/10ps -f filelist.f \
	--top-module stackCpuTb -Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$logFile"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
